/* build.f */
dsp_pkg.sv
instr_store.sv
block_sequencer.sv
channel_file.sv
madd_unit.sv
mem_unit.sv
commit_arbiter.sv
dsp_core.sv
dsp_core_properties.sv
tb_dsp_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the dsp_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_dsp_core \
	-f build.f -o sim_dsp_core; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_dsp_core
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit "$status"
fi

echo "Simulation ended with status 0"
exit 0

/* tb_dsp_core.sv */
module tb_dsp_core;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int RESET_CYCLES = 10;
	localparam int TICK_TO_REQUEST = 5;	// Fetch, read, start and two unit stages

	logic clk;
	logic reset;
	logic tick;
	logic signed [dsp_pkg::DATA_W-1:0] sample_in;
	logic signed [dsp_pkg::DATA_W-1:0] sample_out;
	logic instr_write;
	logic [dsp_pkg::BLK_W-1:0] instr_addr;
	dsp_pkg::instr_word_t instr_data;
	logic busy;

	// Reference model of channels, sample memory and program
	logic signed [dsp_pkg::DATA_W-1:0] model_chan [dsp_pkg::N_CHANNELS];
	logic signed [dsp_pkg::DATA_W-1:0] model_mem [dsp_pkg::MEM_WORDS];
	dsp_pkg::instr_word_t model_prog [dsp_pkg::N_BLOCKS];
	int model_last;
	logic model_any;
	logic run_pending;
	logic signed [dsp_pkg::DATA_W-1:0] sample;

	dsp_core u_dsp_core (
		.clk(clk), .reset(reset), .tick(tick), .sample_in(sample_in),
		.sample_out(sample_out), .instr_write(instr_write), .instr_addr(instr_addr),
		.instr_data(instr_data), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ##############################
	// Model
	// ##############################

	function automatic dsp_pkg::instr_word_t madd_word(input logic [3:0] shift,
			input logic [3:0] dest, input logic [3:0] src_c, input logic [3:0] src_b,
			input logic [3:0] src_a);
		dsp_pkg::instr_word_t w;
		w = '0;
		w.madd.opcode = 1'b0;
		w.madd.shift = shift;
		w.madd.dest = dest;
		w.madd.src_c = src_c;
		w.madd.src_b = src_b;
		w.madd.src_a = src_a;
		return w;
	endfunction

	function automatic dsp_pkg::instr_word_t mem_word(input logic store,
			input logic [7:0] handle, input logic [3:0] dest, input logic [3:0] src_a);
		dsp_pkg::instr_word_t w;
		w = '0;
		w.mem.opcode = 1'b1;
		w.mem.store = store;
		w.mem.handle = handle;
		w.mem.dest = dest;
		w.mem.src_a = src_a;
		return w;
	endfunction

	function automatic logic signed [15:0] madd_result(input logic signed [15:0] a,
			input logic signed [15:0] b, input logic signed [15:0] c, input logic [3:0] shift);
		longint full;
		full = longint'(a) * longint'(b);
		full = full >>> shift;
		full = full + longint'(c);
		if (full > 64'sd32767) begin
			return 16'sh7fff;
		end
		if (full < -64'sd32768) begin
			return 16'sh8000;
		end
		return full[15:0];
	endfunction

	// Blocks run in order, each one seeing the results of the ones before
	task automatic run_program();
		dsp_pkg::instr_word_t w;
		for (int blk = 0; blk <= model_last; blk++) begin
			w = model_prog[blk[5:0]];
			if (!w.madd.opcode) begin
				model_chan[w.madd.dest] = madd_result(model_chan[w.madd.src_a],
					model_chan[w.madd.src_b], model_chan[w.madd.src_c], w.madd.shift);
			end else if (w.mem.store) begin
				model_mem[w.mem.handle] = model_chan[w.mem.src_a];
			end else begin
				model_chan[w.mem.dest] = model_mem[w.mem.handle];
			end
		end
	endtask

	// ##############################
	// Driving and checking
	// ##############################

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		model_chan = '{default: '0};
		model_last = 0;
		model_any = 1'b0;
		run_pending = 1'b0;
	endtask

	task automatic write_block(input logic [5:0] addr, input dsp_pkg::instr_word_t word);
		instr_write = 1'b1;
		instr_addr = addr;
		instr_data = word;
		@(negedge clk);
		instr_write = 1'b0;
		model_prog[addr] = word;
		model_any = 1'b1;
		if (int'(addr) > model_last) begin
			model_last = int'(addr);
		end
	endtask

	// The latch sees channel 0 from before any run this tick starts
	task automatic send_tick(input logic signed [15:0] value);
		logic signed [15:0] expected;
		expected = model_chan[0];
		tick = 1'b1;
		sample_in = value;
		@(negedge clk);
		tick = 1'b0;
		model_chan[1] = value;
		if (model_any) begin
			run_pending = 1'b1;
		end
		assert (sample_out == expected) else report_failure($sformatf(
			"CHECK FAILED sample_out: got %h expected %h", sample_out, expected));
		assert (busy == run_pending) else report_failure($sformatf(
			"CHECK FAILED busy: got %h expected %h", busy, run_pending));
	endtask

	// A repeated sample leaves channel 1 as the first block already read it
	task automatic tick_on_first_request(input logic signed [15:0] value);
		repeat (TICK_TO_REQUEST - 1) @(negedge clk);
		send_tick(value);
	endtask

	task automatic wait_run_end();
		int cycles;
		cycles = 0;
		while (busy) begin
			if (cycles >= TIMEOUT_CYCLES) begin
				report_failure($sformatf("The run did not finish within %0d cycles", cycles));
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		if (run_pending) begin
			run_program();
			run_pending = 1'b0;
		end
	endtask

	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (!busy) else report_failure($sformatf(
				"CHECK FAILED busy: got %h expected %h", busy, 1'b0));
		end
	endtask

	// ##############################
	// Stimulus
	// ##############################

	initial begin
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		instr_write = 1'b0;
		instr_addr = '0;
		instr_data = '0;
		void'($urandom(32'hccbb1feb));
		@(negedge clk);
		apply_reset();

		// Ticks with an empty program only move samples
		for (int i = 0; i < 4; i++) begin
			send_tick(16'($urandom));
		end
		expect_idle(8);

		write_block(6'd0, madd_word(4'd4, 4'd0, 4'd1, 4'd1, 4'd1));
		for (int i = 0; i < 8; i++) begin
			sample = 16'($urandom_range(511, 0)) - 16'd256;
			send_tick(sample);
			if (i == 0) begin
				tick_on_first_request(sample);
			end
			wait_run_end();
		end

		// Channel 2 saturates high, then channel 0 goes to the limit of the sign
		write_block(6'd0, madd_word(4'd0, 4'd2, 4'd3, 4'd1, 4'd1));
		write_block(6'd1, madd_word(4'd0, 4'd0, 4'd1, 4'd2, 4'd1));
		for (int i = 0; i < 7; i++) begin
			sample = 16'($urandom_range(32767, 16384));
			if (i % 2 == 1) begin
				sample = -sample;
			end
			send_tick(sample);
			if (i > 0) begin
				assert (sample_out == 16'h7fff || sample_out == 16'h8000) else
					report_failure($sformatf("CHECK FAILED sample_out: got %h expected %h or %h",
						sample_out, 16'h7fff, 16'h8000));
			end
			wait_run_end();
		end

		write_block(6'd0, mem_word(1'b1, 8'h35, 4'd0, 4'd1));
		write_block(6'd1, mem_word(1'b0, 8'h35, 4'd0, 4'd0));
		for (int i = 0; i < 8; i++) begin
			sample = 16'($urandom);
			send_tick(sample);
			if (i == 0) begin
				tick_on_first_request(sample);
			end
			wait_run_end();
		end

		apply_reset();
		write_block(6'd0, madd_word(4'd4, 4'd0, 4'd1, 4'd1, 4'd1));
		send_tick(16'($urandom_range(511, 0)) - 16'd256);
		send_tick(16'($urandom_range(511, 0)) - 16'd256);	// Lands before the operand read
		wait_run_end();
		expect_idle(6);
		for (int i = 0; i < 2; i++) begin
			send_tick(16'($urandom_range(511, 0)) - 16'd256);
			wait_run_end();
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* dsp_core_properties.sv */
module dsp_core_properties (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic madd_grant,
	input logic mem_grant,
	input dsp_pkg::commit_req_t madd_req,
	input dsp_pkg::commit_req_t mem_req
);

	timeunit 1ns;
	timeprecision 1ps;

	// ##############################
	// Protocol
	// ##############################

	reset_idle: assert property (@(posedge clk)
		reset |=> (!busy && !madd_grant && !mem_grant))
		else $error("Core not idle in the cycle after reset");

	single_grant: assert property (@(posedge clk) disable iff (reset)
		!(madd_grant && mem_grant))
		else $error("Both units granted in one cycle");

	// A request blocked by the tick sample waits with the same fields
	madd_hold: assert property (@(posedge clk) disable iff (reset)
		(madd_req.req && !madd_grant) |=> (madd_req.req && $stable(madd_req)))
		else $error("Multiply-add request changed before its grant");

	mem_hold: assert property (@(posedge clk) disable iff (reset)
		(mem_req.req && !mem_grant) |=> (mem_req.req && $stable(mem_req)))
		else $error("Memory request changed before its grant");

endmodule

bind dsp_core dsp_core_properties u_dsp_core_properties (
	.clk(clk), .reset(reset), .busy(busy), .madd_grant(madd_grant),
	.mem_grant(mem_grant), .madd_req(madd_req), .mem_req(mem_req)
);

/* dsp_core.sv */
module dsp_core (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic signed [dsp_pkg::DATA_W-1:0] sample_in,
	output logic signed [dsp_pkg::DATA_W-1:0] sample_out,
	input logic instr_write,
	input logic [dsp_pkg::BLK_W-1:0] instr_addr,
	input dsp_pkg::instr_word_t instr_data,
	output logic busy
);

	logic [dsp_pkg::BLK_W-1:0] read_addr;
	dsp_pkg::instr_word_t read_data;
	logic [dsp_pkg::BLK_W-1:0] last_block;
	logic any_written;

	logic [dsp_pkg::CH_W-1:0] addr_a;
	logic [dsp_pkg::CH_W-1:0] addr_b;
	logic [dsp_pkg::CH_W-1:0] addr_c;
	logic signed [dsp_pkg::DATA_W-1:0] chan_a;
	logic signed [dsp_pkg::DATA_W-1:0] chan_b;
	logic signed [dsp_pkg::DATA_W-1:0] chan_c;
	logic signed [dsp_pkg::DATA_W-1:0] out_sample;

	logic madd_start;
	logic mem_start;
	dsp_pkg::instr_word_t issue_word;
	logic signed [dsp_pkg::DATA_W-1:0] op_a;
	logic signed [dsp_pkg::DATA_W-1:0] op_b;
	logic signed [dsp_pkg::DATA_W-1:0] op_c;

	dsp_pkg::commit_req_t madd_req;
	dsp_pkg::commit_req_t mem_req;
	logic madd_grant;
	logic mem_grant;
	logic commit_done;
	dsp_pkg::chan_write_t sample_write;
	dsp_pkg::chan_write_t chan_write;

	// ##############################
	// Sample I/O
	// ##############################

	always_comb begin
		sample_write.enable = tick;
		sample_write.addr = dsp_pkg::IN_CHANNEL;
		sample_write.value = sample_in;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_out <= '0;
		end else if (tick) begin
			sample_out <= out_sample;	// Channel 0 as it stands before this tick
		end
	end

	// ##############################
	// Peers
	// ##############################

	instr_store u_instr_store (
		.clk(clk), .reset(reset), .write(instr_write), .write_addr(instr_addr),
		.write_data(instr_data), .read_addr(read_addr), .read_data(read_data),
		.last_block(last_block), .any_written(any_written)
	);

	block_sequencer u_block_sequencer (
		.clk(clk), .reset(reset), .tick(tick), .last_block(last_block),
		.any_written(any_written), .read_data(read_data), .chan_a(chan_a),
		.chan_b(chan_b), .chan_c(chan_c), .commit_done(commit_done),
		.read_addr(read_addr), .addr_a(addr_a), .addr_b(addr_b), .addr_c(addr_c),
		.madd_start(madd_start), .mem_start(mem_start), .issue_word(issue_word),
		.op_a(op_a), .op_b(op_b), .op_c(op_c), .busy(busy)
	);

	channel_file u_channel_file (
		.clk(clk), .reset(reset), .write(chan_write), .addr_a(addr_a), .addr_b(addr_b),
		.addr_c(addr_c), .data_a(chan_a), .data_b(chan_b), .data_c(chan_c),
		.out_sample(out_sample)
	);

	madd_unit u_madd_unit (
		.clk(clk), .reset(reset), .start(madd_start), .word(issue_word), .a(op_a),
		.b(op_b), .c(op_c), .grant(madd_grant), .commit(madd_req)
	);

	mem_unit u_mem_unit (
		.clk(clk), .reset(reset), .start(mem_start), .word(issue_word), .a(op_a),
		.grant(mem_grant), .commit(mem_req)
	);

	commit_arbiter u_commit_arbiter (
		.clk(clk), .reset(reset), .sample_write(sample_write), .madd_req(madd_req),
		.mem_req(mem_req), .madd_grant(madd_grant), .mem_grant(mem_grant),
		.chan_write(chan_write), .commit_done(commit_done)
	);

endmodule

/* commit_arbiter.sv */
module commit_arbiter (
	input logic clk,
	input logic reset,
	input dsp_pkg::chan_write_t sample_write,
	input dsp_pkg::commit_req_t madd_req,
	input dsp_pkg::commit_req_t mem_req,
	output logic madd_grant,
	output logic mem_grant,
	output dsp_pkg::chan_write_t chan_write,
	output logic commit_done
);

	logic unit_granted_q;

	// Fixed priority: tick sample, then madd, then mem
	always_comb begin
		madd_grant = 1'b0;
		mem_grant = 1'b0;
		chan_write = sample_write;
		if (!sample_write.enable && !unit_granted_q) begin	// The sample is never held
			if (madd_req.req) begin
				madd_grant = 1'b1;
				chan_write.enable = madd_req.writes_channel;
				chan_write.addr = madd_req.dest;
				chan_write.value = madd_req.value;
			end else if (mem_req.req) begin
				mem_grant = 1'b1;
				chan_write.enable = mem_req.writes_channel;	// Low for a store
				chan_write.addr = mem_req.dest;
				chan_write.value = mem_req.value;
			end
		end
	end

	assign commit_done = madd_grant | mem_grant;

	// No unit is granted on two cycles in a row
	always_ff @(posedge clk) begin
		if (reset) begin
			unit_granted_q <= 1'b0;
		end else begin
			unit_granted_q <= commit_done;
		end
	end

endmodule

/* mem_unit.sv */
module mem_unit (
	input logic clk,
	input logic reset,
	input logic start,
	input dsp_pkg::instr_word_t word,
	input logic signed [dsp_pkg::DATA_W-1:0] a,
	input logic grant,
	output dsp_pkg::commit_req_t commit
);

	logic signed [dsp_pkg::DATA_W-1:0] ram [dsp_pkg::MEM_WORDS];

	logic accept;
	logic stage1;
	logic req_q;
	logic store_q;
	logic writes_q;
	logic [dsp_pkg::CH_W-1:0] dest_q;
	logic signed [dsp_pkg::DATA_W-1:0] rd_q;
	logic signed [dsp_pkg::DATA_W-1:0] value_q;

	assign accept = start && !stage1 && !req_q;

	// ##############################
	// Sample RAM
	// ##############################

	always_ff @(posedge clk) begin
		if (accept) begin
			if (word.mem.store) begin
				ram[word.mem.handle] <= a;
			end
			rd_q <= ram[word.mem.handle];	// A store reads the old contents and never commits them
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			store_q <= word.mem.store;
			dest_q <= word.mem.dest;
		end
		if (stage1) begin
			writes_q <= !store_q;
			value_q <= rd_q;
		end
	end

	// ##############################
	// Commit request
	// ##############################

	// A store still requests a commit so the sequencer knows it finished
	always_ff @(posedge clk) begin
		if (reset) begin
			stage1 <= 1'b0;
			req_q <= 1'b0;
		end else begin
			stage1 <= accept;
			if (stage1) begin
				req_q <= 1'b1;
			end else if (grant) begin
				req_q <= 1'b0;
			end
		end
	end

	always_comb begin
		commit.req = req_q;
		commit.writes_channel = writes_q;
		commit.dest = dest_q;
		commit.value = value_q;
	end

endmodule

/* madd_unit.sv */
module madd_unit (
	input logic clk,
	input logic reset,
	input logic start,
	input dsp_pkg::instr_word_t word,
	input logic signed [dsp_pkg::DATA_W-1:0] a,
	input logic signed [dsp_pkg::DATA_W-1:0] b,
	input logic signed [dsp_pkg::DATA_W-1:0] c,
	input logic grant,
	output dsp_pkg::commit_req_t commit
);

	logic accept;
	logic stage1;
	logic req_q;
	logic signed [2*dsp_pkg::DATA_W-1:0] product;
	logic signed [dsp_pkg::DATA_W-1:0] c_q;
	logic [dsp_pkg::SHIFT_W-1:0] shift_q;
	logic [dsp_pkg::CH_W-1:0] dest_q;
	logic signed [2*dsp_pkg::DATA_W:0] sum;
	logic signed [dsp_pkg::DATA_W-1:0] clamped;
	logic signed [dsp_pkg::DATA_W-1:0] result_q;

	assign accept = start && !stage1 && !req_q;	// Busy until the commit is granted

	always_ff @(posedge clk) begin
		if (accept) begin
			product <= a * b;
			c_q <= c;
			shift_q <= word.madd.shift;
			dest_q <= word.madd.dest;
		end
		if (stage1) begin
			result_q <= clamped;
		end
	end

	assign sum = (product >>> shift_q) + c_q;

	// Anything that does not fit in 16 bits goes to the nearest limit
	always_comb begin
		if (!sum[2*dsp_pkg::DATA_W] && |sum[2*dsp_pkg::DATA_W-1:dsp_pkg::DATA_W-1]) begin
			clamped = {1'b0, {(dsp_pkg::DATA_W-1){1'b1}}};
		end else if (sum[2*dsp_pkg::DATA_W] && !(&sum[2*dsp_pkg::DATA_W-1:dsp_pkg::DATA_W-1])) begin
			clamped = {1'b1, {(dsp_pkg::DATA_W-1){1'b0}}};
		end else begin
			clamped = sum[dsp_pkg::DATA_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage1 <= 1'b0;
			req_q <= 1'b0;
		end else begin
			stage1 <= accept;
			if (stage1) begin
				req_q <= 1'b1;
			end else if (grant) begin
				req_q <= 1'b0;
			end
		end
	end

	always_comb begin
		commit.req = req_q;
		commit.writes_channel = 1'b1;
		commit.dest = dest_q;
		commit.value = result_q;
	end

endmodule

/* channel_file.sv */
module channel_file (
	input logic clk,
	input logic reset,
	input dsp_pkg::chan_write_t write,
	input logic [dsp_pkg::CH_W-1:0] addr_a,
	input logic [dsp_pkg::CH_W-1:0] addr_b,
	input logic [dsp_pkg::CH_W-1:0] addr_c,
	output logic signed [dsp_pkg::DATA_W-1:0] data_a,
	output logic signed [dsp_pkg::DATA_W-1:0] data_b,
	output logic signed [dsp_pkg::DATA_W-1:0] data_c,
	output logic signed [dsp_pkg::DATA_W-1:0] out_sample
);

	logic signed [dsp_pkg::DATA_W-1:0] chan [dsp_pkg::N_CHANNELS];

	// ##############################
	// Storage
	// ##############################

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dsp_pkg::N_CHANNELS; i++) begin
				chan[i] <= '0;
			end
		end else if (write.enable) begin
			chan[write.addr] <= write.value;	// Single port, shared through the arbiter
		end
	end

	// ##############################
	// Read ports
	// ##############################

	// A read in the write cycle sees the old value
	assign data_a = chan[addr_a];
	assign data_b = chan[addr_b];
	assign data_c = chan[addr_c];

	assign out_sample = chan[dsp_pkg::OUT_CHANNEL];

endmodule

/* block_sequencer.sv */
module block_sequencer (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic [dsp_pkg::BLK_W-1:0] last_block,
	input logic any_written,
	input dsp_pkg::instr_word_t read_data,
	input logic signed [dsp_pkg::DATA_W-1:0] chan_a,
	input logic signed [dsp_pkg::DATA_W-1:0] chan_b,
	input logic signed [dsp_pkg::DATA_W-1:0] chan_c,
	input logic commit_done,
	output logic [dsp_pkg::BLK_W-1:0] read_addr,
	output logic [dsp_pkg::CH_W-1:0] addr_a,
	output logic [dsp_pkg::CH_W-1:0] addr_b,
	output logic [dsp_pkg::CH_W-1:0] addr_c,
	output logic madd_start,
	output logic mem_start,
	output dsp_pkg::instr_word_t issue_word,
	output logic signed [dsp_pkg::DATA_W-1:0] op_a,
	output logic signed [dsp_pkg::DATA_W-1:0] op_b,
	output logic signed [dsp_pkg::DATA_W-1:0] op_c,
	output logic busy
);

	logic [1:0] state;
	logic [dsp_pkg::BLK_W-1:0] block;
	logic is_mem;

	assign is_mem = read_data.mem.opcode;	// Same bit in both views
	assign read_addr = block;
	assign busy = (state != dsp_pkg::SEQ_IDLE);

	// Source a sits in a different place in the two views
	assign addr_a = is_mem ? read_data.mem.src_a : read_data.madd.src_a;
	assign addr_b = read_data.madd.src_b;
	assign addr_c = read_data.madd.src_c;

	// ##############################
	// Run FSM
	// ##############################

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dsp_pkg::SEQ_IDLE;
			block <= '0;
			madd_start <= 1'b0;
			mem_start <= 1'b0;
		end else begin
			madd_start <= 1'b0;
			mem_start <= 1'b0;
			case (state)
				dsp_pkg::SEQ_IDLE: begin
					if (tick && any_written) begin	// A tick during a run is not seen here
						block <= '0;
						state <= dsp_pkg::SEQ_FETCH;
					end
				end
				dsp_pkg::SEQ_FETCH: begin
					state <= dsp_pkg::SEQ_ISSUE;	// Word arrives next cycle
				end
				dsp_pkg::SEQ_ISSUE: begin
					madd_start <= !is_mem;
					mem_start <= is_mem;
					state <= dsp_pkg::SEQ_WAIT;
				end
				default: begin
					if (commit_done) begin
						if (block == last_block) begin
							state <= dsp_pkg::SEQ_IDLE;
						end else begin
							block <= block + 1'b1;
							state <= dsp_pkg::SEQ_FETCH;
						end
					end
				end
			endcase
		end
	end

	// Operands are sampled in the issue cycle and stay put until the next issue
	always_ff @(posedge clk) begin
		if (state == dsp_pkg::SEQ_ISSUE) begin
			issue_word <= read_data;
			op_a <= chan_a;
			op_b <= chan_b;
			op_c <= chan_c;
		end
	end

endmodule

/* instr_store.sv */
module instr_store (
	input logic clk,
	input logic reset,
	input logic write,
	input logic [dsp_pkg::BLK_W-1:0] write_addr,
	input dsp_pkg::instr_word_t write_data,
	input logic [dsp_pkg::BLK_W-1:0] read_addr,
	output dsp_pkg::instr_word_t read_data,
	output logic [dsp_pkg::BLK_W-1:0] last_block,
	output logic any_written
);

	dsp_pkg::instr_word_t blocks [dsp_pkg::N_BLOCKS];

	always_ff @(posedge clk) begin
		if (write) begin
			blocks[write_addr] <= write_data;
		end
		read_data <= blocks[read_addr];	// One cycle of read latency
	end

	// The program always runs from block 0 up to the highest block ever written
	always_ff @(posedge clk) begin
		if (reset) begin
			last_block <= '0;
			any_written <= 1'b0;
		end else if (write) begin
			any_written <= 1'b1;
			if (write_addr >= last_block) begin
				last_block <= write_addr;
			end
		end
	end

endmodule

/* dsp_pkg.sv */
package dsp_pkg;

	// ##############################
	// Sizes
	// ##############################

	localparam int DATA_W = 16;
	localparam int INSTR_W = 32;
	localparam int N_CHANNELS = 16;
	localparam int CH_W = 4;
	localparam int N_BLOCKS = 64;
	localparam int BLK_W = 6;
	localparam int MEM_WORDS = 256;
	localparam int HANDLE_W = 8;
	localparam int SHIFT_W = 4;

	localparam logic [CH_W-1:0] IN_CHANNEL = 4'd1;	// Written by every tick
	localparam logic [CH_W-1:0] OUT_CHANNEL = 4'd0;	// Latched onto sample_out

	// Run states of the block sequencer
	localparam logic [1:0] SEQ_IDLE = 2'd0;
	localparam logic [1:0] SEQ_FETCH = 2'd1;
	localparam logic [1:0] SEQ_ISSUE = 2'd2;
	localparam logic [1:0] SEQ_WAIT = 2'd3;

	// ##############################
	// Instruction word
	// ##############################

	typedef struct packed {
		logic opcode;	// Always 0 here
		logic [SHIFT_W-1:0] shift;
		logic [CH_W-1:0] dest;
		logic [CH_W-1:0] src_c;
		logic [CH_W-1:0] src_b;
		logic [CH_W-1:0] src_a;
		logic [INSTR_W-2-SHIFT_W-4*CH_W:0] pad;
	} madd_fields_t;

	typedef struct packed {
		logic opcode;	// Always 1 here
		logic store;
		logic [HANDLE_W-1:0] handle;
		logic [CH_W-1:0] dest;
		logic [CH_W-1:0] src_a;
		logic [INSTR_W-3-HANDLE_W-2*CH_W:0] pad;
	} mem_fields_t;

	typedef union packed {
		madd_fields_t madd;
		mem_fields_t mem;
	} instr_word_t;

	// ##############################
	// Commit path
	// ##############################

	typedef struct packed {
		logic req;
		logic writes_channel;	// Clear for a store
		logic [CH_W-1:0] dest;
		logic signed [DATA_W-1:0] value;
	} commit_req_t;

	typedef struct packed {
		logic enable;
		logic [CH_W-1:0] addr;
		logic signed [DATA_W-1:0] value;
	} chan_write_t;

endpackage
